//--- mtx_pkg.sv
package mtx_pkg;

  ////////////////////
  // Data path
  ////////////////////

  // Element width, also the width of the size ports
  localparam int DATA_SIZE = 64;

  ////////////////////
  // Matrix limits
  ////////////////////

  // Largest number of input rows
  localparam int MAX_I = 8;

  // Largest number of input columns
  localparam int MAX_J = 8;

  // Largest of the two dimensions
  localparam int MAX_DIM = (MAX_I > MAX_J) ? MAX_I : MAX_J;

  ////////////////////
  // Derived widths
  ////////////////////

  // Row or column index, 0 up to MAX_DIM-1
  localparam int IDX_W = $clog2(MAX_DIM);

  // Clamped size value, 1 up to MAX_DIM
  localparam int CNT_W = $clog2(MAX_DIM + 1);

endpackage

//--- mtx_write_if.sv
`timescale 1ns/10ps

interface mtx_write_if;

  // Write strobe, one element per cycle
  logic                          wr_en;

  // Row and column of the element
  logic [mtx_pkg::IDX_W-1:0]     wr_i;
  logic [mtx_pkg::IDX_W-1:0]     wr_j;

  // Element payload
  logic [mtx_pkg::DATA_SIZE-1:0] wr_data;

  ////////////////////
  // Modports
  ////////////////////

  // Loader side drives everything
  modport loader (
    output wr_en,
    output wr_i,
    output wr_j,
    output wr_data
  );

  // Storage side only listens
  modport buffer (
    input wr_en,
    input wr_i,
    input wr_j,
    input wr_data
  );

endinterface

//--- mtx_read_if.sv
`timescale 1ns/10ps

interface mtx_read_if;

  // Request, one per cycle allowed
  logic                          rd_en;
  logic [mtx_pkg::IDX_W-1:0]     rd_i;
  logic [mtx_pkg::IDX_W-1:0]     rd_j;

  // Response, one cycle after rd_en
  logic [mtx_pkg::DATA_SIZE-1:0] rd_data;
  logic                          rd_valid;

  ////////////////////
  // Modports
  ////////////////////

  // Sequencer issues requests, takes data back
  modport sequencer (
    output rd_en,
    output rd_i,
    output rd_j,
    input  rd_data,
    input  rd_valid
  );

  // Storage answers every request
  modport buffer (
    input  rd_en,
    input  rd_i,
    input  rd_j,
    output rd_data,
    output rd_valid
  );

endinterface

//--- matrix_input_loader.sv
`timescale 1ns/10ps

module matrix_input_loader (
  input  logic                          CLK,
  input  logic                          RST,

  // Control
  input  logic                          START,
  input  logic                          DATA_IN_I_ENABLE,
  input  logic                          DATA_IN_J_ENABLE,

  // Data
  input  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_J_IN,
  input  logic [mtx_pkg::DATA_SIZE-1:0] DATA_IN,

  // Element writes into storage
  mtx_write_if.loader                   wr,

  // Hand-off to the output side
  output logic                          load_done,
  output logic [mtx_pkg::CNT_W-1:0]     size_i,
  output logic [mtx_pkg::CNT_W-1:0]     size_j,
  input  logic                          busy
);

  ////////////////////
  // Signals
  ////////////////////

  // Loading phase flag, low means idle
  logic                      loading;

  // Position of the next incoming element
  logic [mtx_pkg::IDX_W-1:0] row;
  logic [mtx_pkg::IDX_W-1:0] col;

  logic                      in_valid;
  logic                      col_end;
  logic                      row_end;

  // Zero becomes one, too large saturates
  function automatic logic [mtx_pkg::CNT_W-1:0] clamp_size(
    input logic [mtx_pkg::DATA_SIZE-1:0] size_in,
    input int unsigned                   max_size
  );
    logic [mtx_pkg::CNT_W-1:0] result;
    if (size_in == '0) begin
      result = mtx_pkg::CNT_W'(1);
    end else if (size_in > max_size) begin
      result = mtx_pkg::CNT_W'(max_size);
    end else begin
      result = size_in[mtx_pkg::CNT_W-1:0];
    end
    return result;
  endfunction

  ////////////////////
  // Body
  ////////////////////

  // Either enable qualifies data, position comes from the counters
  assign in_valid = DATA_IN_I_ENABLE | DATA_IN_J_ENABLE;

  // Last column of a row, last row of the matrix
  assign col_end = (mtx_pkg::CNT_W'(col) + mtx_pkg::CNT_W'(1)) == size_j;
  assign row_end = (mtx_pkg::CNT_W'(row) + mtx_pkg::CNT_W'(1)) == size_i;

  // Write goes out in the same cycle the element is taken
  assign wr.wr_en   = loading & in_valid;
  assign wr.wr_i    = row;
  assign wr.wr_j    = col;
  assign wr.wr_data = DATA_IN;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      loading   <= 1'b0;
      load_done <= 1'b0;
      row       <= '0;
      col       <= '0;
      size_i    <= mtx_pkg::CNT_W'(1);
      size_j    <= mtx_pkg::CNT_W'(1);
    end else begin
      load_done <= 1'b0;
      if (!loading) begin
        // START only counts while the whole block is idle
        if (START && !busy) begin
          loading <= 1'b1;
          size_i  <= clamp_size(SIZE_I_IN, mtx_pkg::MAX_I);
          size_j  <= clamp_size(SIZE_J_IN, mtx_pkg::MAX_J);
          row     <= '0;
          col     <= '0;
        end
      end else if (in_valid) begin
        // Row-major walk
        if (col_end) begin
          col <= '0;
          if (row_end) begin
            row       <= '0;
            loading   <= 1'b0;
            load_done <= 1'b1;
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

//--- matrix_transpose_buffer.sv
`timescale 1ns/10ps

module matrix_transpose_buffer (
  input  logic CLK,
  input  logic RST,

  // Row-major writes from the loader
  mtx_write_if.buffer wr,

  // Column-major reads from the sequencer
  mtx_read_if.buffer  rd
);

  ////////////////////
  // Storage
  ////////////////////

  // One word per element, flat row-major layout
  logic [mtx_pkg::DATA_SIZE-1:0] mem [mtx_pkg::MAX_I * mtx_pkg::MAX_J];

  int unsigned wr_addr;
  int unsigned rd_addr;

  // Row and column to flat address
  function automatic int unsigned flat_addr(
    input logic [mtx_pkg::IDX_W-1:0] idx_i,
    input logic [mtx_pkg::IDX_W-1:0] idx_j
  );
    return int'(idx_i) * mtx_pkg::MAX_J + int'(idx_j);
  endfunction

  ////////////////////
  // Body
  ////////////////////

  // Same mapping on both ports, so the transpose is only in the read order
  assign wr_addr = flat_addr(wr.wr_i, wr.wr_j);
  assign rd_addr = flat_addr(rd.rd_i, rd.rd_j);

  // Write port
  always_ff @(posedge CLK) begin
    if (wr.wr_en) begin
      mem[wr_addr] <= wr.wr_data;
    end
  end

  // Registered read data, no reset on the payload
  always_ff @(posedge CLK) begin
    if (rd.rd_en) begin
      rd.rd_data <= mem[rd_addr];
    end
  end

  // Valid follows the request by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd.rd_valid <= 1'b0;
    end else begin
      rd.rd_valid <= rd.rd_en;
    end
  end

endmodule

//--- matrix_output_sequencer.sv
`timescale 1ns/10ps

module matrix_output_sequencer (
  input  logic                          CLK,
  input  logic                          RST,

  // From the loader
  input  logic                          load_done,
  input  logic [mtx_pkg::CNT_W-1:0]     size_i,
  input  logic [mtx_pkg::CNT_W-1:0]     size_j,

  // Buffer reads
  mtx_read_if.sequencer                 rd,

  // Keeps the loader from taking a new START
  output logic                          busy,

  // Output stream
  output logic                          READY,
  output logic                          DATA_OUT_I_ENABLE,
  output logic                          DATA_OUT_J_ENABLE,
  output logic [mtx_pkg::DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////
  // Signals
  ////////////////////

  // Read walk still running after the first request
  logic                      reading;

  // Output order position, j outer and i inner
  logic [mtx_pkg::IDX_W-1:0] cnt_i;
  logic [mtx_pkg::IDX_W-1:0] cnt_j;

  logic                      end_i;
  logic                      end_j;

  // Tags riding alongside the buffer latency
  logic                      tag_first;
  logic                      tag_last;

  // Last element now on DATA_OUT
  logic                      out_last;

  // Set from load_done until READY
  logic                      busy_q;

  ////////////////////
  // Read walk
  ////////////////////

  // First request in the load_done cycle itself
  assign rd.rd_en = load_done | reading;
  // Counters sit at zero when idle
  assign rd.rd_i  = cnt_i;
  assign rd.rd_j  = cnt_j;

  assign end_i = (mtx_pkg::CNT_W'(cnt_i) + mtx_pkg::CNT_W'(1)) == size_i;
  assign end_j = (mtx_pkg::CNT_W'(cnt_j) + mtx_pkg::CNT_W'(1)) == size_j;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      reading   <= 1'b0;
      cnt_i     <= '0;
      cnt_j     <= '0;
      tag_first <= 1'b0;
      tag_last  <= 1'b0;
    end else begin
      // Tags follow each request by one cycle, like the data
      tag_first <= rd.rd_en & (cnt_i == '0);
      tag_last  <= rd.rd_en & end_i & end_j;
      if (rd.rd_en) begin
        if (end_i) begin
          cnt_i <= '0;
          if (end_j) begin
            cnt_j   <= '0;
            reading <= 1'b0;
          end else begin
            cnt_j   <= cnt_j + 1'b1;
            reading <= 1'b1;
          end
        end else begin
          cnt_i   <= cnt_i + 1'b1;
          reading <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Output framing
  ////////////////////

  // Covers the load_done cycle before busy_q rises
  assign busy = load_done | busy_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT          <= '0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      out_last          <= 1'b0;
      READY             <= 1'b0;
      busy_q            <= 1'b0;
    end else begin
      // Row start picks I, the rest of the row gets J
      DATA_OUT_I_ENABLE <= rd.rd_valid & tag_first;
      DATA_OUT_J_ENABLE <= rd.rd_valid & ~tag_first;
      out_last          <= rd.rd_valid & tag_last;
      if (rd.rd_valid) begin
        DATA_OUT <= rd.rd_data;
      end
      // One pulse after the final element
      READY <= out_last;
      if (load_done) begin
        busy_q <= 1'b1;
      end else if (out_last) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- accelerator_matrix_transpose.sv
`timescale 1ns/10ps

module accelerator_matrix_transpose (
  // Global
  input  logic                          CLK,
  input  logic                          RST,

  // Control
  input  logic                          START,
  output logic                          READY,

  input  logic                          DATA_IN_I_ENABLE,
  input  logic                          DATA_IN_J_ENABLE,
  output logic                          DATA_OUT_I_ENABLE,
  output logic                          DATA_OUT_J_ENABLE,

  // Data
  input  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_J_IN,
  input  logic [mtx_pkg::DATA_SIZE-1:0] DATA_IN,
  output logic [mtx_pkg::DATA_SIZE-1:0] DATA_OUT
);

  ////////////////////
  // Signals
  ////////////////////

  // Loader to sequencer hand-off
  logic                      load_done;
  logic [mtx_pkg::CNT_W-1:0] size_i;
  logic [mtx_pkg::CNT_W-1:0] size_j;

  // Output side still draining
  logic                      busy;

  // Internal buses
  mtx_write_if wr_bus ();
  mtx_read_if  rd_bus ();

  ////////////////////
  // Body
  ////////////////////

  // Row-major input, sizes latched on START
  matrix_input_loader u_loader (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_I_ENABLE(DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE(DATA_IN_J_ENABLE),
    .SIZE_I_IN       (SIZE_I_IN),
    .SIZE_J_IN       (SIZE_J_IN),
    .DATA_IN         (DATA_IN),
    .wr              (wr_bus.loader),
    .load_done       (load_done),
    .size_i          (size_i),
    .size_j          (size_j),
    .busy            (busy)
  );

  // Element store
  matrix_transpose_buffer u_buffer (
    .CLK(CLK),
    .RST(RST),
    .wr (wr_bus.buffer),
    .rd (rd_bus.buffer)
  );

  // Column-major readout with I/J framing
  matrix_output_sequencer u_sequencer (
    .CLK              (CLK),
    .RST              (RST),
    .load_done        (load_done),
    .size_i           (size_i),
    .size_j           (size_j),
    .rd               (rd_bus.sequencer),
    .busy             (busy),
    .READY            (READY),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .DATA_OUT         (DATA_OUT)
  );

endmodule

//--- tb_matrix_transpose.sv
`timescale 1ns/10ps

module tb_matrix_transpose;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                          CLK = 1'b0;
  logic                          RST;
  logic                          START;
  logic                          READY;
  logic                          DATA_IN_I_ENABLE;
  logic                          DATA_IN_J_ENABLE;
  logic                          DATA_OUT_I_ENABLE;
  logic                          DATA_OUT_J_ENABLE;
  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_I_IN;
  logic [mtx_pkg::DATA_SIZE-1:0] SIZE_J_IN;
  logic [mtx_pkg::DATA_SIZE-1:0] DATA_IN;
  logic [mtx_pkg::DATA_SIZE-1:0] DATA_OUT;

  // Matrix as sent
  logic [mtx_pkg::DATA_SIZE-1:0] mat [mtx_pkg::MAX_I][mtx_pkg::MAX_J];
  // Outputs still owed with the row-start flag as top bit
  logic [mtx_pkg::DATA_SIZE:0]   exp_q [$];
  logic [mtx_pkg::DATA_SIZE:0]   exp_e;
  string                         test_name = "reset";
  int                            run_count;
  int                            seed = 32'h84941f30;

  // Monitor bookkeeping counted in sampled clock edges
  int cyc = 0;
  int last_in_cyc = 0;
  int last_out_cyc = 0;
  int out_idx = 0;
  int watchdog_cycles;

  accelerator_matrix_transpose u_dut (.*);

  // 4 ns period
  always #2 CLK = ~CLK;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at first error");
  endtask

  // Zero means one and anything too large saturates
  function automatic int clamp_dim(input logic [mtx_pkg::DATA_SIZE-1:0] v, input int max_dim);
    if (v == '0) return 1;
    if (v > max_dim) return max_dim;
    return int'(v);
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  a_one_enable: assert property (@(posedge CLK) disable iff (RST)
    !(DATA_OUT_I_ENABLE && DATA_OUT_J_ENABLE))
    else fail_run("both output enables high in the same cycle");

  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else fail_run("READY held high for more than one cycle");

  // Sees the pre-edge values just like the DUT
  always @(posedge CLK) begin
    cyc = cyc + 1;
    if (DATA_IN_I_ENABLE || DATA_IN_J_ENABLE) last_in_cyc = cyc;
    if (DATA_OUT_I_ENABLE || DATA_OUT_J_ENABLE) begin
      assert (exp_q.size() > 0) else fail_run("output element arrived with nothing expected");
      exp_e = exp_q.pop_front();
      assert ({DATA_OUT_I_ENABLE, DATA_OUT} == exp_e) else fail_run($sformatf(
        "mismatch %s element %0d expected %h actual %h",
        test_name, out_idx, exp_e, {DATA_OUT_I_ENABLE, DATA_OUT}));
      // Accepted at edge L and registered at L+2 so seen at L+3
      if (out_idx == 0) begin
        assert (cyc == last_in_cyc + 3)
          else fail_run({"first output of ", test_name, " not two cycles after last input"});
      end else begin
        assert (cyc == last_out_cyc + 1)
          else fail_run({"gap in the output stream of ", test_name});
      end
      last_out_cyc = cyc;
      out_idx = out_idx + 1;
    end
    if (READY) begin
      assert (out_idx > 0 && cyc == last_out_cyc + 1)
        else fail_run({"READY of ", test_name, " not one cycle after the last output"});
      assert (out_idx == run_count && exp_q.size() == 0) else fail_run($sformatf(
        "mismatch %s output count expected %0d actual %0d", test_name, run_count, out_idx));
      out_idx = 0;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Called right after a clock edge and returns at the edge READY is seen
  task automatic run_matrix(input string name, input logic [mtx_pkg::DATA_SIZE-1:0] si_in,
                            input logic [mtx_pkg::DATA_SIZE-1:0] sj_in,
                            input bit counting, input bit poke_start);
    int si;
    int sj;
    START     <= 1'b1;
    SIZE_I_IN <= si_in;
    SIZE_J_IN <= sj_in;
    @(posedge CLK);
    START     <= 1'b0;
    test_name = name;
    si = clamp_dim(si_in, mtx_pkg::MAX_I);
    sj = clamp_dim(sj_in, mtx_pkg::MAX_J);
    run_count = si * sj;
    // Row-major fill
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        if (counting) mat[i][j] = mtx_pkg::DATA_SIZE'(i * sj + j);
        else mat[i][j] = {$random(seed), $random(seed)};
      end
    end
    // Transposed order with the row start on i == 0
    for (int j = 0; j < sj; j++) begin
      for (int i = 0; i < si; i++) begin
        exp_q.push_back({i == 0, mat[i][j]});
      end
    end
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        DATA_IN          <= mat[i][j];
        DATA_IN_I_ENABLE <= (j == 0);
        DATA_IN_J_ENABLE <= (j != 0);
        // One START in the middle of loading when poking
        START            <= poke_start && (i == 1) && (j == 0);
        @(posedge CLK);
      end
    end
    DATA_IN_I_ENABLE <= 1'b0;
    DATA_IN_J_ENABLE <= 1'b0;
    START            <= 1'b0;
    // START with other sizes while the output side is busy
    if (poke_start) begin
      @(posedge CLK);
      START     <= 1'b1;
      SIZE_I_IN <= 2;
      SIZE_J_IN <= 3;
      @(posedge CLK);
      START     <= 1'b0;
    end
    do @(posedge CLK); while (!READY);
  endtask

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN          = '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    // Outputs quiet before any START
    repeat (6) begin
      @(posedge CLK);
      assert (!READY && !DATA_OUT_I_ENABLE && !DATA_OUT_J_ENABLE && DATA_OUT == '0)
        else fail_run("outputs active after reset before any START");
    end
    run_matrix("square_4x4_counting", 4, 4, 1'b1, 1'b0);
    run_matrix("rect_3x8_random", 3, 8, 1'b0, 1'b0);
    run_matrix("rect_8x2_random", 8, 2, 1'b0, 1'b0);
    run_matrix("start_while_busy", 4, 4, 1'b0, 1'b1);
    // Starts right after READY of the one before
    run_matrix("back_to_back_6x5", 6, 5, 1'b0, 1'b0);
    run_matrix("clamp_0x12", 0, 12, 1'b0, 1'b0);
    repeat (4) @(posedge CLK);
    $display("NO ERRORS");
    $finish;
  end

  // Twice the element count of all runs plus slack for reset and run overhead
  initial begin
    watchdog_cycles = 2 * (16 + 24 + 16 + 16 + 30 + 8) + 200;
    #(watchdog_cycles * 4);
    fail_run("watchdog expired before all tests finished");
  end

endmodule

//--- sim.f
mtx_pkg.sv
mtx_write_if.sv
mtx_read_if.sv
matrix_input_loader.sv
matrix_transpose_buffer.sv
matrix_output_sequencer.sv
accelerator_matrix_transpose.sv
tb_matrix_transpose.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_matrix_transpose
FILELIST = sim.f
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
